//--- rtl/pmu_ahb_slave.sv
// PMU AHB-lite slave
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_ahb_slave (
    input  wire                                            clk_i,
    input  wire                                            rstn_i,
    input  wire pmu_pkg::ahb_req_t                         ahb_req_i,
    input  wire [`PMU_REG_WIDTH-1:0]                       cfg_i,
    input  wire [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0]  counts_i,
    input  wire [`PMU_N_COUNTERS-1:0]                      status_i,
    input  wire [`PMU_N_COUNTERS-1:0]                      mask_i,
    output pmu_pkg::reg_wr_t                               wr_o,
    output pmu_pkg::ahb_rsp_t                              ahb_rsp_o
);

    // ----------------------------------------------------------
    // Address phase
    // ----------------------------------------------------------

    pmu_pkg::htrans_e                state_d;
    pmu_pkg::htrans_e                state_q;
    logic                            accept;
    logic                            write_q;
    logic [`PMU_IDX_WIDTH-1:0]       index_q;
    logic                            data_phase;
    logic [`PMU_IDX_WIDTH-1:0]       cnt_off;
    logic [`PMU_REG_WIDTH-1:0]       rdata;

    // Real transfer only for NONSEQ and SEQ while selected and bus ready
    assign accept = ahb_req_i.sel && ahb_req_i.ready_in &&
                    ((ahb_req_i.trans == pmu_pkg::NONSEQ) ||
                     (ahb_req_i.trans == pmu_pkg::SEQ));

    // Unselected slots fall back to IDLE, IDLE and BUSY kept but inert
    assign state_d = (ahb_req_i.sel && ahb_req_i.ready_in) ? ahb_req_i.trans : pmu_pkg::IDLE;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= pmu_pkg::IDLE;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Write flag only meaningful for an accepted transfer
            write_q <= accept && ahb_req_i.write;
        end
    end

    // Word index of the accepted transfer
    always_ff @(posedge clk_i) begin
        if (accept) begin
            index_q <= ahb_req_i.addr[`PMU_IDX_WIDTH+1:2];
        end
    end

    // ----------------------------------------------------------
    // Data phase
    // ----------------------------------------------------------

    // One cycle long, never stretched
    assign data_phase = (state_q == pmu_pkg::NONSEQ) || (state_q == pmu_pkg::SEQ);

    // Write request to the register owners, data comes with hwdata
    assign wr_o.valid = data_phase && write_q;
    assign wr_o.index = index_q;
    assign wr_o.data  = ahb_req_i.wdata;

    // Counter slot relative to the first counter index
    assign cnt_off = index_q - `PMU_IDX_WIDTH'(`PMU_REG_CNT0);

    // Read mux
    always_comb begin
        rdata = '0;
        if (index_q == `PMU_REG_CFG) begin
            rdata = cfg_i;
        end else if ((index_q >= `PMU_REG_CNT0) &&
                     (index_q < (`PMU_REG_CNT0 + `PMU_N_COUNTERS))) begin
            rdata = counts_i[cnt_off[$clog2(`PMU_N_COUNTERS)-1:0]];
        end else if (index_q == `PMU_REG_OVF) begin
            rdata = {{(`PMU_REG_WIDTH-`PMU_N_COUNTERS){1'b0}}, status_i};
        end else if (index_q == `PMU_REG_MASK) begin
            rdata = {{(`PMU_REG_WIDTH-`PMU_N_COUNTERS){1'b0}}, mask_i};
        end
        // Anything else stays 0
    end

    // No wait states and no error responses
    assign ahb_rsp_o.ready_out = 1'b1;
    assign ahb_rsp_o.resp      = pmu_pkg::OKAY;
    assign ahb_rsp_o.rdata     = rdata;

endmodule

`default_nettype wire

//--- rtl/pmu_counter_bank.sv
// PMU event counter bank
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_counter_bank (
    input  wire                                            clk_i,
    input  wire                                            rstn_i,
    input  wire pmu_pkg::reg_wr_t                          wr_i,
    input  wire [`PMU_N_COUNTERS-1:0]                      events_i,
    output logic [`PMU_REG_WIDTH-1:0]                      cfg_o,
    output logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counts_o,
    output logic [`PMU_N_COUNTERS-1:0]                     wrap_o
);

    // ----------------------------------------------------------
    // Configuration register
    // ----------------------------------------------------------

    logic [`PMU_REG_WIDTH-1:0]                      cfg_q;
    logic [`PMU_REG_WIDTH-1:0]                      cfg_d;
    logic                                           cfg_wr;
    logic                                           srst;
    logic                                           enable;
    logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] cnt_q;
    logic [`PMU_N_COUNTERS-1:0]                     cnt_wr;
    logic [`PMU_N_COUNTERS-1:0]                     inc;

    assign cfg_wr = wr_i.valid && (wr_i.index == `PMU_REG_CFG);

    // Soft reset acts at the write edge and is never stored
    assign srst = cfg_wr && wr_i.data[`PMU_CFG_SRST_BIT];

    // Counting uses the enable held before this edge
    assign enable = cfg_q[`PMU_CFG_EN_BIT];

    // Next config value for a write
    always_comb begin
        cfg_d = wr_i.data;
        cfg_d[`PMU_CFG_SRST_BIT] = 1'b0;
        if (srst) begin
            // Only the enable survives a soft reset write
            cfg_d = '0;
            cfg_d[`PMU_CFG_EN_BIT] = wr_i.data[`PMU_CFG_EN_BIT];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q <= '0;
        end else if (cfg_wr) begin
            cfg_q <= cfg_d;
        end
    end

    // ----------------------------------------------------------
    // Counters
    // ----------------------------------------------------------

    // Per-counter write select, increment and wrap
    always_comb begin
        for (int n = 0; n < `PMU_N_COUNTERS; n++) begin
            cnt_wr[n] = wr_i.valid && (wr_i.index == (`PMU_REG_CNT0 + n));
            // A bus write or soft reset takes the event of this cycle
            inc[n]    = enable && !srst && !cnt_wr[n] && events_i[n];
            // All-ones plus one rolls over to 0
            wrap_o[n] = inc[n] && (&cnt_q[n]);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else begin
            for (int n = 0; n < `PMU_N_COUNTERS; n++) begin
                if (srst) begin
                    cnt_q[n] <= '0;
                end else if (cnt_wr[n]) begin
                    cnt_q[n] <= wr_i.data;
                end else if (inc[n]) begin
                    cnt_q[n] <= cnt_q[n] + 1'b1;  // carry out dropped
                end
            end
        end
    end

    // Register values for the read mux
    assign cfg_o    = cfg_q;
    assign counts_o = cnt_q;

endmodule

`default_nettype wire

//--- rtl/pmu_macros.svh
// PMU widths and register map
`ifndef PMU_MACROS_SVH
`define PMU_MACROS_SVH

// ----------------------------------------------------------
// Bus and register widths
// ----------------------------------------------------------

// Data bus and register width
`define PMU_REG_WIDTH 32
// AHB address width
`define PMU_ADDR_WIDTH 32
// Counters, one per event input
`define PMU_N_COUNTERS 8
// Word index taken from address bits 5:2
`define PMU_IDX_WIDTH 4

// ----------------------------------------------------------
// Register map, word indices
// ----------------------------------------------------------

// Configuration register
`define PMU_REG_CFG 0
// First counter, the others follow in order
`define PMU_REG_CNT0 1
// Sticky overflow status, write 1 to clear
`define PMU_REG_OVF 9
// Overflow interrupt mask
`define PMU_REG_MASK 10

// Configuration register fields
`define PMU_CFG_EN_BIT 0
`define PMU_CFG_SRST_BIT 1

`endif

//--- rtl/pmu_overflow_unit.sv
// PMU overflow status and interrupt
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_overflow_unit (
    input  wire                             clk_i,
    input  wire                             rstn_i,
    input  wire pmu_pkg::reg_wr_t           wr_i,
    input  wire [`PMU_N_COUNTERS-1:0]       wrap_i,
    output logic [`PMU_N_COUNTERS-1:0]      status_o,
    output logic [`PMU_N_COUNTERS-1:0]      mask_o,
    output logic                            intr_overflow_o
);

    // ----------------------------------------------------------
    // Register writes
    // ----------------------------------------------------------

    logic [`PMU_N_COUNTERS-1:0] status_q;
    logic [`PMU_N_COUNTERS-1:0] mask_q;
    logic [`PMU_N_COUNTERS-1:0] clr;
    logic                       ovf_wr;
    logic                       mask_wr;

    assign ovf_wr  = wr_i.valid && (wr_i.index == `PMU_REG_OVF);
    assign mask_wr = wr_i.valid && (wr_i.index == `PMU_REG_MASK);

    // Write 1 to clear, upper data bits ignored
    assign clr = ovf_wr ? wr_i.data[`PMU_N_COUNTERS-1:0] : '0;

    // ----------------------------------------------------------
    // Sticky status and mask
    // ----------------------------------------------------------

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            status_q <= '0;
        end else begin
            // Wrap in the same cycle beats the clear
            status_q <= (status_q & ~clr) | wrap_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mask_q <= '0;
        end else if (mask_wr) begin
            mask_q <= wr_i.data[`PMU_N_COUNTERS-1:0];
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    assign status_o = status_q;
    assign mask_o   = mask_q;

    // Any unmasked overflow raises the line
    assign intr_overflow_o = |(status_q & mask_q);

endmodule

`default_nettype wire

//--- rtl/pmu_pkg.sv
// PMU shared types
`default_nettype none

`include "pmu_macros.svh"

package pmu_pkg;

    // ----------------------------------------------------------
    // AHB-lite encodings
    // ----------------------------------------------------------

    // Transfer type, htrans
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Response type, hresp
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_e;

    // ----------------------------------------------------------
    // Bus bundles
    // ----------------------------------------------------------

    // Manager to slave, 69 bits
    typedef struct packed {
        logic                       sel;
        logic                       ready_in;
        logic [`PMU_ADDR_WIDTH-1:0] addr;
        logic                       write;
        htrans_e                    trans;
        logic [`PMU_REG_WIDTH-1:0]  wdata;
    } ahb_req_t;

    // Slave to manager, 34 bits
    typedef struct packed {
        logic                      ready_out;
        hresp_e                    resp;
        logic [`PMU_REG_WIDTH-1:0] rdata;
    } ahb_rsp_t;

    // Register write request, one data-phase cycle, 37 bits
    typedef struct packed {
        logic                      valid;
        logic [`PMU_IDX_WIDTH-1:0] index;
        logic [`PMU_REG_WIDTH-1:0] data;
    } reg_wr_t;

endpackage

`default_nettype wire

//--- rtl/pmu_top.sv
// PMU top level
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_top (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire pmu_pkg::ahb_req_t      ahb_req_i,
    input  wire [`PMU_N_COUNTERS-1:0]   events_i,
    output pmu_pkg::ahb_rsp_t           ahb_rsp_o,
    output logic                        intr_overflow_o
);

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------

    pmu_pkg::reg_wr_t                               wr;
    logic [`PMU_REG_WIDTH-1:0]                      cfg;
    logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counts;
    logic [`PMU_N_COUNTERS-1:0]                     wrap;
    logic [`PMU_N_COUNTERS-1:0]                     status;
    logic [`PMU_N_COUNTERS-1:0]                     mask;

    // Bus side, decodes transfers and muxes read data
    pmu_ahb_slave u_slave (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .ahb_req_i (ahb_req_i),
        .cfg_i     (cfg),
        .counts_i  (counts),
        .status_i  (status),
        .mask_i    (mask),
        .wr_o      (wr),
        .ahb_rsp_o (ahb_rsp_o)
    );

    // Config register and event counters
    pmu_counter_bank u_counters (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wr_i     (wr),
        .events_i (events_i),
        .cfg_o    (cfg),
        .counts_o (counts),
        .wrap_o   (wrap)
    );

    // Overflow status, mask and interrupt
    pmu_overflow_unit u_overflow (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wr_i            (wr),
        .wrap_i          (wrap),
        .status_o        (status),
        .mask_o          (mask),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/pmu_pkg.sv
rtl/pmu_ahb_slave.sv
rtl/pmu_counter_bank.sv
rtl/pmu_overflow_unit.sv
rtl/pmu_top.sv
test/pmu_clkgen.sv
test/pmu_checker.sv
test/pmu_assert.sv
test/pmu_tb.sv

//--- test/pmu_assert.sv
// PMU bus and interrupt assertions
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_assert (
    input wire                          clk_i,
    input wire                          rstn_i,
    input wire pmu_pkg::ahb_rsp_t       ahb_rsp_i,
    input wire [`PMU_N_COUNTERS-1:0]    status_i,
    input wire [`PMU_N_COUNTERS-1:0]    mask_i,
    input wire                          intr_overflow_i
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Zero wait state slave
    a_ready: assert property (@(posedge clk_i) disable iff (!rstn_i) ahb_rsp_i.ready_out)
        else begin
            $error("AHB ready_out dropped low");
            fail_cnt++;
        end

    a_okay: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ahb_rsp_i.resp == pmu_pkg::OKAY)
        else begin
            $error("AHB response was not OKAY");
            fail_cnt++;
        end

    // Interrupt is the OR of the unmasked status bits
    a_intr: assert property (@(posedge clk_i) disable iff (!rstn_i)
        intr_overflow_i == |(status_i & mask_i))
        else begin
            $error("Overflow interrupt does not match masked status");
            fail_cnt++;
        end

endmodule

bind pmu_top pmu_assert u_assert (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .ahb_rsp_i       (ahb_rsp_o),
    .status_i        (status),
    .mask_i          (mask),
    .intr_overflow_i (intr_overflow_o)
);

`default_nettype wire

//--- test/pmu_checker.sv
// PMU reference model and checker
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_checker (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire pmu_pkg::ahb_req_t      ahb_req_i,
    input  wire [`PMU_N_COUNTERS-1:0]   events_i,
    input  wire pmu_pkg::ahb_rsp_t      ahb_rsp_i,
    input  wire                         intr_overflow_i,
    output int                          reads_o,
    output int                          read_err_o,
    output int                          intr_err_o,
    output int                          bus_err_o
);

    // Model of the register map
    logic [`PMU_REG_WIDTH-1:0]  cfg_m;
    logic [`PMU_REG_WIDTH-1:0]  cnt_m [`PMU_N_COUNTERS];
    logic [`PMU_N_COUNTERS-1:0] ovf_m;
    logic [`PMU_N_COUNTERS-1:0] mask_m;
    // Transfer whose data phase is running
    logic                       dp_valid;
    logic                       dp_write;
    logic [`PMU_IDX_WIDTH-1:0]  dp_idx;

    // Expected read data for a word index
    function automatic logic [`PMU_REG_WIDTH-1:0] model_read(input logic [3:0] idx);
        if (idx == `PMU_REG_CFG)
            return cfg_m;
        if (idx >= `PMU_REG_CNT0 && idx < `PMU_REG_CNT0 + `PMU_N_COUNTERS)
            return cnt_m[idx - `PMU_REG_CNT0];
        if (idx == `PMU_REG_OVF)
            return {24'b0, ovf_m};
        if (idx == `PMU_REG_MASK)
            return {24'b0, mask_m};
        return '0;
    endfunction

    // ----------------------------------------------------------
    // Compare, then step the model at the same edge as the DUT
    // ----------------------------------------------------------

    always @(posedge clk_i or negedge rstn_i) begin
        logic [`PMU_N_COUNTERS-1:0] wrap;
        logic                       wr;
        logic                       srst;
        logic                       en;
        logic [`PMU_REG_WIDTH-1:0]  wdata;
        if (!rstn_i) begin
            cfg_m = '0;
            for (int n = 0; n < `PMU_N_COUNTERS; n++)
                cnt_m[n] = '0;
            ovf_m    = '0;
            mask_m   = '0;
            dp_valid = 1'b0;
            dp_write = 1'b0;
            dp_idx   = '0;
        end else begin
            // Read data of the data phase ending here
            if (dp_valid && !dp_write) begin
                reads_o++;
                if (ahb_rsp_i.rdata !== model_read(dp_idx)) begin
                    read_err_o++;
                    $display("[FAIL] read reg %0d: expected %h, actual %h",
                             dp_idx, model_read(dp_idx), ahb_rsp_i.rdata);
                end
            end
            // Interrupt every cycle
            if (intr_overflow_i !== |(ovf_m & mask_m)) begin
                intr_err_o++;
                $display("[FAIL] intr_overflow: expected %b, actual %b",
                         |(ovf_m & mask_m), intr_overflow_i);
            end
            if (ahb_rsp_i.ready_out !== 1'b1 || ahb_rsp_i.resp !== pmu_pkg::OKAY) begin
                bus_err_o++;
                $display("Slave was not ready or answered ERROR at %0t", $time);
            end
            // Write effects, enable taken from before this edge
            wr    = dp_valid && dp_write;
            wdata = ahb_req_i.wdata;
            srst  = wr && dp_idx == `PMU_REG_CFG && wdata[`PMU_CFG_SRST_BIT];
            en    = cfg_m[`PMU_CFG_EN_BIT];
            wrap  = '0;
            for (int n = 0; n < `PMU_N_COUNTERS; n++) begin
                if (srst) begin
                    cnt_m[n] = '0;
                end else if (wr && dp_idx == `PMU_REG_CNT0 + n) begin
                    cnt_m[n] = wdata;
                end else if (en && events_i[n]) begin
                    wrap[n]  = &cnt_m[n];
                    cnt_m[n] = cnt_m[n] + 1;
                end
            end
            if (wr && dp_idx == `PMU_REG_CFG)
                cfg_m = srst ? {31'b0, wdata[`PMU_CFG_EN_BIT]} : (wdata & ~32'h2);
            // Wrap wins over the write-1-to-clear
            if (wr && dp_idx == `PMU_REG_OVF)
                ovf_m = ovf_m & ~wdata[`PMU_N_COUNTERS-1:0];
            ovf_m = ovf_m | wrap;
            if (wr && dp_idx == `PMU_REG_MASK)
                mask_m = wdata[`PMU_N_COUNTERS-1:0];
            // Next address phase
            dp_valid = ahb_req_i.sel && ahb_req_i.ready_in &&
                       (ahb_req_i.trans == pmu_pkg::NONSEQ || ahb_req_i.trans == pmu_pkg::SEQ);
            dp_write = ahb_req_i.write;
            dp_idx   = ahb_req_i.addr[5:2];
        end
    end

endmodule

`default_nettype wire

//--- test/pmu_clkgen.sv
// PMU clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module pmu_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held low for the first 5 rising edges
    initial begin
        rstn_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/pmu_tb.sv
// PMU testbench top
`timescale 1ns/1ps
`default_nettype none

`include "pmu_macros.svh"

module pmu_tb;

    // Random transfers at one per cycle
    localparam int N_XFERS    = 3000;
    // Twice the nominal run plus the reset window
    localparam int TIMEOUT_NS = N_XFERS * 4 * 2 + 5 * 4;

    wire                        clk;
    wire                        rstn;
    pmu_pkg::ahb_req_t          ahb_req;
    pmu_pkg::ahb_rsp_t          ahb_rsp;
    logic [`PMU_N_COUNTERS-1:0] events;
    logic                       intr;
    int                         reads;
    int                         read_err;
    int                         intr_err;
    int                         bus_err;
    integer                     seed;

    pmu_clkgen u_clkgen (.clk_o(clk), .rstn_o(rstn));

    pmu_top UUT (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .ahb_req_i       (ahb_req),
        .events_i        (events),
        .ahb_rsp_o       (ahb_rsp),
        .intr_overflow_o (intr)
    );

    pmu_checker u_checker (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .ahb_req_i       (ahb_req),
        .events_i        (events),
        .ahb_rsp_i       (ahb_rsp),
        .intr_overflow_i (intr),
        .reads_o         (reads),
        .read_err_o      (read_err),
        .intr_err_o      (intr_err),
        .bus_err_o       (bus_err)
    );

    // Write data shaped by the register being written
    function automatic logic [31:0] pick_wdata(input logic [3:0] idx);
        logic [31:0] r;
        r = $random(seed);
        if (idx == `PMU_REG_CFG) begin
            // Mostly enabled with a soft reset about one time in eight
            r[`PMU_CFG_EN_BIT]   = (r[7:4] != 4'h0);
            r[`PMU_CFG_SRST_BIT] = (r[10:8] == 3'h0);
        end else if (idx >= `PMU_REG_CNT0 && idx < `PMU_REG_CNT0 + `PMU_N_COUNTERS && r[31]) begin
            r = 32'hffff_ffff - r[2:0];  // close to the wrap
        end
        return r;
    endfunction

    // ----------------------------------------------------------
    // Random AHB stimulus
    // ----------------------------------------------------------

    initial begin : stimulus
        pmu_pkg::ahb_req_t nxt;
        logic [3:0]        idx;
        logic [3:0]        prev_idx;
        logic [2:0]        kind;
        seed     = 32'hd26e671f;
        ahb_req  = '0;
        ahb_req.ready_in = 1'b1;
        events   = '0;
        prev_idx = '0;
        wait (rstn === 1'b1);
        for (int t = 0; t < N_XFERS; t++) begin
            @(posedge clk);
            kind = 3'($random(seed));
            // Mostly inside the map and sometimes in the unmapped tail
            if (($random(seed) & 7) != 0)
                idx = 4'($unsigned($random(seed)) % 11);
            else
                idx = 4'(11 + $unsigned($random(seed)) % 5);
            nxt.sel      = ($random(seed) & 7) != 0;
            nxt.ready_in = ($random(seed) & 15) != 0;
            nxt.write    = ($random(seed) & 1) != 0;
            if (kind < 2)
                nxt.trans = kind[0] ? pmu_pkg::BUSY : pmu_pkg::IDLE;
            else
                nxt.trans = kind[0] ? pmu_pkg::SEQ : pmu_pkg::NONSEQ;
            nxt.addr  = {26'($random(seed)), idx, 2'b00};
            // Data phase of the previous address phase
            nxt.wdata = pick_wdata(prev_idx);
            ahb_req  <= nxt;
            events   <= 8'($random(seed));
            prev_idx  = idx;
        end
        // Close the last data phase
        @(posedge clk);
        nxt          = '0;
        nxt.ready_in = 1'b1;
        nxt.wdata    = pick_wdata(prev_idx);
        ahb_req     <= nxt;
        repeat (3) @(posedge clk);
        $display("Reads checked %0d, errors read %0d intr %0d bus %0d assert %0d",
                 reads, read_err, intr_err, bus_err, UUT.u_assert.fail_cnt);
        if (reads == 0)
            $display("No read data phase was checked during the run");
        if (read_err + intr_err + bus_err + UUT.u_assert.fail_cnt == 0 && reads > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Run timed out after %0t before the stimulus finished", $time);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
